// ==== list.f ====
rtl/tft_pkg.sv
rtl/tft_step_timer.sv
rtl/tft_bus_writer.sv
rtl/sdram_quad_reader.sv
rtl/tft_sequencer.sv
rtl/tft_adapter_top.sv
dv/sdram_frame_model.sv
dv/tb_tft_adapter.sv

// ==== Makefile ====
TOP := tb_tft_adapter
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module tft_adapter_top rtl/tft_pkg.sv \
		rtl/tft_step_timer.sv rtl/tft_bus_writer.sv rtl/sdram_quad_reader.sv \
		rtl/tft_sequencer.sv rtl/tft_adapter_top.sv

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/tb_tft_adapter.sv ====
`timescale 1ns/1ps

module tb_tft_adapter;

    localparam int width      = 4;
    localparam int height     = 3;
    localparam int sleep_cyc  = 20;
    localparam int hold_cyc   = 50;
    localparam int gap_cyc    = 30;
    localparam int pixels     = width * height;
    localparam int frames_run = 2;
    localparam logic [tft_pkg::addr_w-1:0] last_burst = tft_pkg::addr_w'(pixels - 4);

    // Eight window pairs plus RAMWR, and the writes of each phase.
    localparam int win_writes  = 17;
    localparam int init_writes = 2 + win_writes + pixels + 3;
    localparam int frame_writes = win_writes + pixels;

    // Generous cycle budget per bus write and per SDRAM burst.
    localparam int write_cyc    = 6;
    localparam int burst_cyc    = 12;
    localparam int init_budget  = 10 + tft_pkg::reset_low_cycles + sleep_cyc + hold_cyc
                                  + init_writes * write_cyc;
    localparam int frame_budget = gap_cyc + 2 * write_cyc + frame_writes * write_cyc
                                  + (pixels / 4) * burst_cyc;
    localparam int timeout_cyc  = 2 * (init_budget + 3 * frame_budget);

    logic                        clk;
    logic                        rst_n;
    logic                        sdram_rd_done;
    logic [tft_pkg::data_w-1:0]  sdram_data0, sdram_data1, sdram_data2, sdram_data3;
    logic [tft_pkg::addr_w-1:0]  sdram_rd_addr;
    logic                        sdram_rd_req, frame_active;
    logic                        lcd_rst, lcd_bl, lcd_cs, lcd_rs, lcd_wr;
    logic [tft_pkg::data_w-1:0]  lcd_data;

    int                          errors = 0;
    int                          checks = 0;
    int unsigned                 cycle = 0;
    logic [16:0]                 exp_q [$];     // {rs, word} in bus order.
    logic [16:0]                 exp_word;
    int                          writes_seen = 0;
    int unsigned                 first_cmd_cycle;
    int                          frames_started = 0;
    int                          frames_done = 0;
    bit                          wr_prev = 1'b1;
    bit                          req_prev, fa_prev;
    logic [tft_pkg::addr_w-1:0]  held_addr;
    logic [tft_pkg::addr_w-1:0]  next_addr = '0;

    initial clk = 1'b0;
    always #2 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    tft_adapter_top #(
        .frame_width  (width),
        .frame_height (height),
        .sleep_cycles (sleep_cyc),
        .hold_cycles  (hold_cyc),
        .gap_cycles   (gap_cyc)
    ) uut (
        .clk, .rst_n, .sdram_rd_done,
        .sdram_data0, .sdram_data1, .sdram_data2, .sdram_data3,
        .sdram_rd_addr, .sdram_rd_req, .frame_active,
        .lcd_rst, .lcd_bl, .lcd_cs, .lcd_rs, .lcd_wr, .lcd_data
    );

    sdram_frame_model u_sdram (
        .clk, .rst_n,
        .rd_req (sdram_rd_req), .rd_addr (sdram_rd_addr), .rd_done (sdram_rd_done),
        .data0 (sdram_data0), .data1 (sdram_data1),
        .data2 (sdram_data2), .data3 (sdram_data3)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checks and expected stream.
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error: %s at %0t", what, $time);
        end
    endtask

    task automatic check_reset_outputs();
        check_value("lcd_rst", 32'(lcd_rst), 32'd0);
        check_value("lcd_bl", 32'(lcd_bl), 32'd0);
        check_value("lcd_cs", 32'(lcd_cs), 32'd1);
        check_value("lcd_rs", 32'(lcd_rs), 32'd1);
        check_value("lcd_wr", 32'(lcd_wr), 32'd1);
        check_value("sdram_rd_req", 32'(sdram_rd_req), 32'd0);
        check_value("frame_active", 32'(frame_active), 32'd0);
    endtask

    task automatic push_write(input bit rs, input logic [15:0] word);
        exp_q.push_back({rs, word});
    endtask

    // CASET then RASET, 0 to last, high byte first, then RAMWR.
    task automatic push_window();
        logic [15:0] base, lim;
        int          i;
        for (i = 0; i < 8; i++) begin
            base = (i < 4) ? tft_pkg::cmd_caset : tft_pkg::cmd_raset;
            lim  = (i < 4) ? 16'(width - 1) : 16'(height - 1);
            push_write(1'b0, base | 16'(i % 4));
            case (i % 4)
                2:       push_write(1'b1, {8'h00, lim[15:8]});
                3:       push_write(1'b1, {8'h00, lim[7:0]});
                default: push_write(1'b1, 16'h0000);
            endcase
        end
        push_write(1'b0, tft_pkg::cmd_ramwr);
    endtask

    task automatic build_expected();
        int p;
        push_write(1'b0, tft_pkg::cmd_sleep_out);
        push_write(1'b0, tft_pkg::cmd_display_on);
        push_window();
        repeat (pixels) push_write(1'b1, tft_pkg::color_red);
        push_write(1'b0, tft_pkg::cmd_display_on);
        push_write(1'b0, tft_pkg::cmd_scan_dir);
        push_write(1'b1, 16'h0000);
        repeat (frames_run) begin
            push_window();
            for (p = 0; p < pixels; p++) push_write(1'b1, 16'hA500 ^ 16'(p)); // Addr p.
        end
    endtask

    task automatic end_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus monitors sampled on the falling edge.
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            // Panel write completes on lcd_wr rising.
            if (lcd_wr && !wr_prev) begin
                check_true(!lcd_cs, "panel write outside a low chip select");
                check_value("lcd_rst", 32'(lcd_rst), 32'd1);    // Panel out of reset.
                check_value("lcd_bl", 32'(lcd_bl), 32'd1);
                check_value("frame_active", 32'(frame_active),
                            32'(writes_seen >= init_writes));
                if (exp_q.size() == 0) begin
                    check_true(1'b0, "panel write with none expected");
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value("lcd_rs", 32'(lcd_rs), 32'(exp_word[16]));
                    check_value("lcd_data", 32'(lcd_data), 32'(exp_word[15:0]));
                end
                if (writes_seen == 0) first_cmd_cycle = cycle;
                if (writes_seen == 1) begin
                    check_true(cycle - first_cmd_cycle >= sleep_cyc,
                               "display on came before the settle delay");
                end
                writes_seen++;
            end
            // SDRAM request order and hold until done.
            if (sdram_rd_req && !req_prev) begin
                check_true(frame_active, "SDRAM read outside a frame");
                check_value("sdram_rd_addr", 32'(sdram_rd_addr), 32'(next_addr));
                held_addr = sdram_rd_addr;
                next_addr = (next_addr == last_burst) ? '0 : next_addr + 4;
            end else if (sdram_rd_req) begin
                check_value("sdram_rd_addr", 32'(sdram_rd_addr), 32'(held_addr));
            end else if (req_prev) begin
                check_true(sdram_rd_done, "sdram_rd_req dropped before sdram_rd_done");
            end
            // Frame framing.
            if (frame_active && !fa_prev) frames_started++;
            if (!frame_active && fa_prev) begin
                frames_done++;
                check_true(writes_seen == init_writes + frames_done * frame_writes,
                           "wrong number of panel writes in the frame");
                $display("Frame %0d done at cycle %0d", frames_done, cycle);
            end
            if (frames_started > 0 && !frame_active) begin
                check_value("lcd_cs", 32'(lcd_cs), 32'd1);    // Idle between frames.
            end
        end
        wr_prev  = lcd_wr;
        req_prev = sdram_rd_req;
        fa_prev  = frame_active;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main flow and watchdog.
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_n = 1'b0;
        build_expected();
        repeat (10) @(negedge clk) check_reset_outputs();
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_outputs();      // Just out of reset.
        wait (frames_done == frames_run);
        @(negedge clk);
        check_true(exp_q.size() == 0, "expected panel writes never arrived");
        end_run();
    end

    initial begin
        repeat (timeout_cyc) @(posedge clk);
        errors++;
        $display("Timeout: %0d of %0d frames done after %0d cycles",
                 frames_done, frames_run, timeout_cyc);
        end_run();
    end

endmodule

// ==== dv/sdram_frame_model.sv ====
`timescale 1ns/1ps

module sdram_frame_model (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_req,
    input  logic [tft_pkg::addr_w-1:0]  rd_addr,
    output logic                        rd_done,
    output logic [tft_pkg::data_w-1:0]  data0,
    output logic [tft_pkg::data_w-1:0]  data1,
    output logic [tft_pkg::data_w-1:0]  data2,
    output logic [tft_pkg::data_w-1:0]  data3
);

    localparam logic [15:0] fill_base = 16'hA500;   // XOR'd with the word address.

    int unsigned wait_left;     // Cycles still to wait on this request.
    bit          waiting;
    bit          seeded;

    initial begin
        rd_done = 1'b0;
        data0   = '0;
        data1   = '0;
        data2   = '0;
        data3   = '0;
    end

    // Word k of the burst at address a.
    function automatic logic [15:0] word_at(input logic [tft_pkg::addr_w-1:0] a, input int k);
        logic [tft_pkg::addr_w-1:0] sum;
        sum = a + tft_pkg::addr_w'(k);
        return fill_base ^ sum[15:0];
    endfunction

    // Answers on the falling edge 0 to 7 cycles after the request is seen.
    always @(negedge clk) begin
        if (!seeded) begin
            void'($urandom(32'h5701));      // Seeds this process's generator.
            seeded = 1'b1;
        end
        if (!rst_n) begin
            rd_done <= 1'b0;
            waiting = 1'b0;
        end else if (rd_done) begin
            rd_done <= 1'b0;                // Request has dropped by now.
        end else if (rd_req) begin
            if (!waiting) begin
                wait_left = $urandom % 8;
                waiting   = 1'b1;
            end
            if (wait_left == 0) begin
                rd_done <= 1'b1;
                data0   <= word_at(rd_addr, 0);
                data1   <= word_at(rd_addr, 1);
                data2   <= word_at(rd_addr, 2);
                data3   <= word_at(rd_addr, 3);
                waiting = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

// ==== rtl/tft_adapter_top.sv ====
`timescale 1ns/1ps

module tft_adapter_top #(
    parameter int frame_width  = tft_pkg::default_width,
    parameter int frame_height = tft_pkg::default_height,
    parameter int sleep_cycles = tft_pkg::default_sleep_cycles,
    parameter int hold_cycles  = tft_pkg::default_hold_cycles,
    parameter int gap_cycles   = tft_pkg::default_gap_cycles
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // SDRAM read side.
    input  logic                        sdram_rd_done,
    input  logic [tft_pkg::data_w-1:0]  sdram_data0,
    input  logic [tft_pkg::data_w-1:0]  sdram_data1,
    input  logic [tft_pkg::data_w-1:0]  sdram_data2,
    input  logic [tft_pkg::data_w-1:0]  sdram_data3,
    output logic [tft_pkg::addr_w-1:0]  sdram_rd_addr,
    output logic                        sdram_rd_req,
    output logic                        frame_active,
    // Panel pins.
    output logic                        lcd_rst,
    output logic                        lcd_bl,
    output logic                        lcd_cs,
    output logic                        lcd_rs,
    output logic                        lcd_wr,
    output logic [tft_pkg::data_w-1:0]  lcd_data
);

    logic                        op_start, op_done;
    logic [1:0]                  op_code;
    logic [tft_pkg::data_w-1:0]  op_data;
    logic                        load, step, expired, timer_free_run;
    logic [tft_pkg::count_w-1:0] load_value;
    logic                        fetch, advance, words_ready, frame_end;
    logic [1:0]                  word_sel;
    logic [tft_pkg::data_w-1:0]  pixel;

    // Fill count loads while a data op is held; delays follow cmd or cs ops.
    assign timer_free_run = (op_code != tft_pkg::op_data);

    tft_sequencer #(
        .frame_width  (frame_width),
        .frame_height (frame_height),
        .sleep_cycles (sleep_cycles),
        .hold_cycles  (hold_cycles),
        .gap_cycles   (gap_cycles)
    ) u_sequencer (
        .clk, .rst_n, .op_done, .expired, .words_ready, .frame_end, .pixel,
        .op_start, .op_code, .op_data, .load, .load_value, .step,
        .fetch, .word_sel, .advance, .frame_active
    );

    tft_step_timer u_timer (
        .clk, .rst_n, .load, .load_value, .step,
        .free_run (timer_free_run),
        .expired
    );

    tft_bus_writer u_bus_writer (
        .clk, .rst_n, .op_start, .op_code, .op_data, .op_done,
        .lcd_rst, .lcd_bl, .lcd_cs, .lcd_rs, .lcd_wr, .lcd_data
    );

    sdram_quad_reader #(
        .frame_pixels (frame_width * frame_height)
    ) u_reader (
        .clk, .rst_n, .fetch, .advance, .word_sel, .sdram_rd_done,
        .sdram_data0, .sdram_data1, .sdram_data2, .sdram_data3,
        .sdram_rd_req, .sdram_rd_addr, .words_ready, .pixel, .frame_end
    );

endmodule

// ==== rtl/tft_sequencer.sv ====
`timescale 1ns/1ps

module tft_sequencer #(
    parameter int frame_width  = tft_pkg::default_width,
    parameter int frame_height = tft_pkg::default_height,
    parameter int sleep_cycles = tft_pkg::default_sleep_cycles,
    parameter int hold_cycles  = tft_pkg::default_hold_cycles,
    parameter int gap_cycles   = tft_pkg::default_gap_cycles
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        op_done,
    input  logic                        expired,
    input  logic                        words_ready,
    input  logic                        frame_end,
    input  logic [tft_pkg::data_w-1:0]  pixel,
    output logic                        op_start,
    output logic [1:0]                  op_code,
    output logic [tft_pkg::data_w-1:0]  op_data,
    output logic                        load,
    output logic [tft_pkg::count_w-1:0] load_value,
    output logic                        step,
    output logic                        fetch,
    output logic [1:0]                  word_sel,
    output logic                        advance,
    output logic                        frame_active
);

    // Last column and row, sent high byte first.
    localparam logic [15:0] x_end     = 16'(frame_width - 1);
    localparam logic [15:0] y_end     = 16'(frame_height - 1);
    localparam logic [1:0]  last_word = 2'(tft_pkg::burst_words - 3'd1);

    enum logic [4:0] {
        ST_PANEL_RST, ST_CS_LOW0, ST_SLEEP_OUT, ST_SLEEP, ST_DISP_ON0, ST_CS_HIGH0,
        ST_CS_LOW1, ST_WIN, ST_RAMWR, ST_FILL_LOAD, ST_FILL, ST_FILL_CHK,
        ST_DISP_ON1, ST_SCAN_CMD, ST_SCAN_DATA, ST_CS_HIGH1, ST_HOLD, ST_GAP,
        ST_FETCH, ST_PIXEL, ST_CS_HIGH2
    } state, after;

    logic                        busy;      // Op or count in flight.
    logic                        clearing;  // Window feeds the red fill.
    logic [3:0]                  win_idx;   // CASET/RASET cmd and data, 16 ops.
    logic [1:0]                  issue_code;
    logic [tft_pkg::data_w-1:0]  issue_data, win_end;
    logic [tft_pkg::count_w-1:0] wait_value;

    assign step    = (state == ST_FILL) && op_done;     // One per red pixel.
    assign advance = (state == ST_PIXEL) && op_done && (word_sel == last_word);

    ////////////////////////////////////////////////////////////////////////////
    // Per-state operation and successor.
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        issue_code = tft_pkg::op_cmd;
        issue_data = '0;
        wait_value = '0;
        after      = state;
        win_end    = win_idx[3] ? y_end : x_end;        // RASET half uses rows.
        case (state)
            ST_PANEL_RST: begin
                issue_code = tft_pkg::op_reset;
                after      = ST_CS_LOW0;
            end
            ST_CS_LOW0: begin
                issue_code = tft_pkg::op_cs;
                after      = ST_SLEEP_OUT;
            end
            ST_SLEEP_OUT: begin
                issue_data = tft_pkg::cmd_sleep_out;
                after      = ST_SLEEP;
            end
            ST_SLEEP: begin
                wait_value = sleep_cycles;
                after      = ST_DISP_ON0;
            end
            ST_DISP_ON0: begin
                issue_data = tft_pkg::cmd_display_on;
                after      = ST_CS_HIGH0;
            end
            ST_CS_HIGH0: begin
                issue_code = tft_pkg::op_cs;
                issue_data = 16'd1;
                after      = ST_CS_LOW1;
            end
            ST_CS_LOW1: begin
                issue_code = tft_pkg::op_cs;
                after      = ST_WIN;
            end
            ST_WIN: begin
                if (win_idx[0]) begin                   // Odd index is the data.
                    issue_code = tft_pkg::op_data;
                    case (win_idx[2:1])
                        2'd2:    issue_data = {8'h00, win_end[15:8]};
                        2'd3:    issue_data = {8'h00, win_end[7:0]};
                        default: issue_data = '0;       // Start is 0.
                    endcase
                end else begin
                    issue_data = (win_idx[3] ? tft_pkg::cmd_raset : tft_pkg::cmd_caset)
                                 | {14'd0, win_idx[2:1]};
                end
                after = (win_idx == 4'd15) ? ST_RAMWR : ST_WIN;
            end
            ST_RAMWR: begin
                issue_data = tft_pkg::cmd_ramwr;
                after      = clearing ? ST_FILL_LOAD : ST_FETCH;
            end
            ST_FILL: begin
                issue_code = tft_pkg::op_data;
                issue_data = tft_pkg::color_red;
                after      = ST_FILL_CHK;
            end
            ST_DISP_ON1: begin
                issue_data = tft_pkg::cmd_display_on;
                after      = ST_SCAN_CMD;
            end
            ST_SCAN_CMD: begin
                issue_data = tft_pkg::cmd_scan_dir;
                after      = ST_SCAN_DATA;
            end
            ST_SCAN_DATA: begin
                issue_code = tft_pkg::op_data;          // Default orientation.
                after      = ST_CS_HIGH1;
            end
            ST_CS_HIGH1: begin
                issue_code = tft_pkg::op_cs;
                issue_data = 16'd1;
                after      = ST_HOLD;
            end
            ST_HOLD: begin
                wait_value = hold_cycles;
                after      = ST_GAP;
            end
            ST_GAP: begin
                wait_value = gap_cycles;
                after      = ST_CS_LOW1;
            end
            ST_PIXEL: begin
                issue_code = tft_pkg::op_data;
                issue_data = pixel;
                if (word_sel != last_word) after = ST_PIXEL;
                else                       after = frame_end ? ST_CS_HIGH2 : ST_FETCH;
            end
            ST_CS_HIGH2: begin
                issue_code = tft_pkg::op_cs;
                issue_data = 16'd1;
                after      = ST_GAP;
            end
            default: after = state;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue, wait and advance.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_PANEL_RST;
            busy         <= 1'b0;
            clearing     <= 1'b1;
            win_idx      <= '0;
            word_sel     <= '0;
            op_start     <= 1'b0;
            op_code      <= tft_pkg::op_reset;
            load         <= 1'b0;
            fetch        <= 1'b0;
            frame_active <= 1'b0;
        end else begin
            op_start <= 1'b0;
            load     <= 1'b0;
            fetch    <= 1'b0;
            case (state)
                ST_SLEEP, ST_HOLD, ST_GAP: begin
                    if (!busy) begin
                        load       <= 1'b1;
                        load_value <= wait_value;
                        busy       <= 1'b1;
                    end else if (expired) begin
                        busy  <= 1'b0;
                        state <= after;
                        if (state == ST_GAP) frame_active <= 1'b1;  // Frame begins.
                    end
                end
                ST_FILL_LOAD: begin
                    load       <= 1'b1;
                    load_value <= frame_width * frame_height;
                    op_code    <= tft_pkg::op_data;     // Selects step mode.
                    state      <= ST_FILL;
                end
                ST_FILL_CHK: begin
                    if (expired) begin                  // Last red pixel sent.
                        clearing <= 1'b0;
                        state    <= ST_DISP_ON1;
                    end else begin
                        state <= ST_FILL;
                    end
                end
                ST_FETCH: begin
                    if (!busy) begin
                        fetch <= 1'b1;
                        busy  <= 1'b1;
                    end else if (words_ready) begin
                        busy  <= 1'b0;
                        state <= ST_PIXEL;
                    end
                end
                default: begin
                    if (!busy) begin
                        op_start <= 1'b1;
                        op_code  <= issue_code;
                        op_data  <= issue_data;
                        busy     <= 1'b1;
                    end else if (op_done) begin
                        busy  <= 1'b0;
                        state <= after;
                        if (state == ST_WIN)      win_idx      <= win_idx + 4'd1;
                        if (state == ST_PIXEL)    word_sel     <= word_sel + 2'd1;
                        if (state == ST_CS_HIGH2) frame_active <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/sdram_quad_reader.sv ====
`timescale 1ns/1ps

module sdram_quad_reader #(
    parameter int frame_pixels = tft_pkg::default_width * tft_pkg::default_height
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch,
    input  logic                        advance,
    input  logic [1:0]                  word_sel,
    input  logic                        sdram_rd_done,
    input  logic [tft_pkg::data_w-1:0]  sdram_data0,
    input  logic [tft_pkg::data_w-1:0]  sdram_data1,
    input  logic [tft_pkg::data_w-1:0]  sdram_data2,
    input  logic [tft_pkg::data_w-1:0]  sdram_data3,
    output logic                        sdram_rd_req,
    output logic [tft_pkg::addr_w-1:0]  sdram_rd_addr,
    output logic                        words_ready,
    output logic [tft_pkg::data_w-1:0]  pixel,
    output logic                        frame_end
);

    // Start of the last burst in the frame.
    localparam logic [tft_pkg::addr_w-1:0] last_addr =
        tft_pkg::addr_w'(frame_pixels - tft_pkg::burst_words);
    localparam logic [tft_pkg::addr_w-1:0] addr_step = tft_pkg::burst_words;

    logic [tft_pkg::data_w-1:0] words [4];
    logic                       capture;

    assign capture   = sdram_rd_req && sdram_rd_done;
    assign pixel     = words[word_sel];
    assign frame_end = advance && (sdram_rd_addr == last_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_rd_req  <= 1'b0;
            sdram_rd_addr <= '0;
            words_ready   <= 1'b0;
        end else begin
            if (fetch) begin
                sdram_rd_req <= 1'b1;   // Held with the address until done.
            end else if (capture) begin
                sdram_rd_req <= 1'b0;
                words_ready  <= 1'b1;
            end
            if (advance) begin
                words_ready   <= 1'b0;
                sdram_rd_addr <= (sdram_rd_addr == last_addr) ? '0
                                                              : sdram_rd_addr + addr_step;
            end
        end
    end

    // Burst buffer.
    always_ff @(posedge clk) begin
        if (capture) begin
            words[0] <= sdram_data0;
            words[1] <= sdram_data1;
            words[2] <= sdram_data2;
            words[3] <= sdram_data3;
        end
    end

endmodule

// ==== rtl/tft_bus_writer.sv ====
`timescale 1ns/1ps

module tft_bus_writer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        op_start,
    input  logic [1:0]                  op_code,
    input  logic [tft_pkg::data_w-1:0]  op_data,
    output logic                        op_done,
    output logic                        lcd_rst,
    output logic                        lcd_bl,
    output logic                        lcd_cs,
    output logic                        lcd_rs,
    output logic                        lcd_wr,
    output logic [tft_pkg::data_w-1:0]  lcd_data
);

    localparam int rst_cnt_w = $clog2(tft_pkg::reset_low_cycles);

    enum logic [1:0] {PH_IDLE, PH_STROBE, PH_RELEASE, PH_RESET} phase;

    logic [rst_cnt_w-1:0] rst_cnt;
    logic                 write_start;

    // Data or command write accepted this cycle.
    assign write_start = (phase == PH_IDLE) && op_start &&
                         ((op_code == tft_pkg::op_data) || (op_code == tft_pkg::op_cmd));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= PH_IDLE;
            rst_cnt <= '0;
            op_done <= 1'b0;
            lcd_rst <= 1'b0;    // Panel held in reset.
            lcd_bl  <= 1'b0;
            lcd_cs  <= 1'b1;
            lcd_rs  <= 1'b1;
            lcd_wr  <= 1'b1;
        end else begin
            op_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (write_start) begin
                        lcd_rs <= (op_code == tft_pkg::op_data);   // Low for cmd.
                        lcd_wr <= 1'b0;
                        phase  <= PH_STROBE;
                    end else if (op_start && op_code == tft_pkg::op_cs) begin
                        lcd_cs  <= op_data[0];
                        op_done <= 1'b1;
                    end else if (op_start) begin                    // Reset pulse.
                        lcd_rst <= 1'b0;
                        rst_cnt <= rst_cnt_w'(tft_pkg::reset_low_cycles - 1);
                        phase   <= PH_RESET;
                    end
                end
                PH_STROBE: begin
                    lcd_wr <= 1'b1;     // Panel latches on this edge.
                    phase  <= PH_RELEASE;
                end
                PH_RELEASE: begin
                    op_done <= 1'b1;
                    phase   <= PH_IDLE;
                end
                PH_RESET: begin
                    if (rst_cnt == '0) begin
                        lcd_rst <= 1'b1;
                        lcd_bl  <= 1'b1;   // Backlight on once out of reset.
                        op_done <= 1'b1;
                        phase   <= PH_IDLE;
                    end else begin
                        rst_cnt <= rst_cnt - 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // Bus value held between writes.
    always_ff @(posedge clk) begin
        if (write_start) lcd_data <= op_data;
    end

endmodule

// ==== rtl/tft_step_timer.sv ====
`timescale 1ns/1ps

module tft_step_timer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  logic [tft_pkg::count_w-1:0] load_value,
    input  logic                        step,
    input  logic                        free_run,
    output logic                        expired
);

    logic [tft_pkg::count_w-1:0] remaining;
    logic                        running;
    logic                        by_step;   // Mode latched at load.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
            running   <= 1'b0;
            by_step   <= 1'b0;
            expired   <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (load) begin
                remaining <= load_value;
                running   <= (load_value != '0);    // Zero count never fires.
                by_step   <= !free_run;
            end else if (running && (!by_step || step)) begin
                remaining <= remaining - 1'b1;
                if (remaining == 1) begin           // Count reached, one pulse.
                    expired <= 1'b1;
                    running <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== rtl/tft_pkg.sv ====
package tft_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and memory widths.
    ////////////////////////////////////////////////////////////////////////////
    localparam int data_w  = 16;                // Panel bus and SDRAM word.
    localparam int addr_w  = 24;                // Bank(2) + row(13) + column(9).
    localparam int count_w = 32;                // Step timer width.

    // Words returned by one SDRAM read.
    localparam logic [2:0] burst_words = 3'd4;

    ////////////////////////////////////////////////////////////////////////////
    // Panel command words.
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [data_w-1:0] cmd_sleep_out  = 16'h1100;
    localparam logic [data_w-1:0] cmd_display_on = 16'h2900;
    localparam logic [data_w-1:0] cmd_caset      = 16'h2A00; // Low byte is param index.
    localparam logic [data_w-1:0] cmd_raset      = 16'h2B00; // Low byte is param index.
    localparam logic [data_w-1:0] cmd_ramwr      = 16'h2C00;
    localparam logic [data_w-1:0] cmd_scan_dir   = 16'h3600;

    // RGB565 clear colour.
    localparam logic [data_w-1:0] color_red = 16'hF800;

    ////////////////////////////////////////////////////////////////////////////
    // Default panel geometry and delays, in clock cycles.
    ////////////////////////////////////////////////////////////////////////////
    localparam int default_width        = 480;
    localparam int default_height       = 800;
    localparam int default_sleep_cycles = 500;          // Settle after sleep out.
    localparam int default_hold_cycles  = 160_000_000;  // Red screen hold.
    localparam int default_gap_cycles   = 80_000;       // Between frames.

    localparam int reset_low_cycles = 16;   // Panel reset pulse.

    // Bus writer operations.
    localparam logic [1:0] op_reset = 2'd0;
    localparam logic [1:0] op_cs    = 2'd1; // op_data[0] is the new chip select.
    localparam logic [1:0] op_data  = 2'd2;
    localparam logic [1:0] op_cmd   = 2'd3;

endpackage
